// File: include/decoder_settings.svh
`ifndef DECODER_SETTINGS_SVH
`define DECODER_SETTINGS_SVH

// width of one instruction word
`define INST_W 32

// ----------------------------------------------------------------------
// opcode prefixes
// ----------------------------------------------------------------------
// every prefix starts at bit 31, each value below is the lowest bit
// of a prefix of that length
`define OP6_MSB  26
`define OP7_MSB  25
`define OP8_MSB  24
`define OP10_MSB 22
`define OP17_MSB 15
`define OP22_MSB 10    // only ertn needs a prefix this long

`endif

// File: design/decode_pkg.sv
`include "decoder_settings.svh"

package decode_pkg;

    // ------------------------------------------------------------------
    // operand and immediate kinds
    // ------------------------------------------------------------------
    typedef enum logic [1:0] {REG_R0_NONE, REG_R0_RD, REG_R0_RK, REG_R0_IMM} reg_r0_e;
    typedef enum logic       {REG_R1_NONE, REG_R1_RJ} reg_r1_e;
    typedef enum logic [1:0] {REG_W_NONE, REG_W_RD, REG_W_BL1} reg_w_e;
    typedef enum logic [1:0] {IMM_U5, IMM_S12, IMM_U12, IMM_S20} imm_e;
    typedef enum logic [1:0] {ADDR_IMM_S12, ADDR_IMM_S14, ADDR_IMM_S16, ADDR_IMM_S26} addr_imm_e;

    // ------------------------------------------------------------------
    // execution controls
    // ------------------------------------------------------------------
    typedef enum logic [1:0] {GTYPE_BW, GTYPE_LI, GTYPE_INT, GTYPE_SFT} alu_gtype_e;

    // sub-op codes repeat from group to group, so they are plain constants
    typedef logic [2:0] alu_stype_t;
    localparam alu_stype_t STYPE_NOR = 3'd0, STYPE_AND = 3'd1, STYPE_OR = 3'd2, STYPE_XOR = 3'd3;
    localparam alu_stype_t STYPE_LUI = 3'd0, STYPE_PCADDUI = 3'd1, STYPE_PCPLUS4 = 3'd2;
    localparam alu_stype_t STYPE_ADD = 3'd0, STYPE_SUB = 3'd1, STYPE_SLT = 3'd2, STYPE_SLTU = 3'd3;
    localparam alu_stype_t STYPE_SLL = 3'd0, STYPE_SRL = 3'd1, STYPE_SRA = 3'd2;
    localparam alu_stype_t MDU_MULL = 3'd0, MDU_MULH = 3'd1, MDU_MULHU = 3'd2, MDU_DIV = 3'd3;
    localparam alu_stype_t MDU_MOD = 3'd4, MDU_DIVU = 3'd5, MDU_MODU = 3'd6;

    typedef enum logic       {TARGET_ABS, TARGET_REL} target_e;
    typedef enum logic [3:0] {
        CMP_NOCONDITION, CMP_E, CMP_NE, CMP_LT, CMP_GE, CMP_LTU, CMP_GEU
    } cmp_e;
    typedef enum logic [2:0] {MEM_BYTE, MEM_HALF, MEM_WORD, MEM_UBYTE, MEM_UHALF} mem_e;

    typedef struct packed {
        logic [`INST_W-1:0] inst;
        logic               alu_inst;
        logic               mdu_inst;
        logic               lsu_inst;
        reg_r0_e            reg_type_r0;
        reg_r1_e            reg_type_r1;
        reg_w_e             reg_type_w;
        imm_e               imm_type;
        addr_imm_e          addr_imm_type;
        logic               slot0;        // issues alone in the first slot
        alu_gtype_e         alu_grand_op;
        alu_stype_t         alu_op;
        target_e            target_type;
        cmp_e               cmp_type;
        logic               jump_inst;
        mem_e               mem_type;
        logic               mem_read;
        logic               mem_write;
        logic               llsc_inst;
        logic               priv_inst;
        logic               csr_op_en;
        logic               syscall_inst;
        logic               break_inst;
        logic               ertn_inst;
        logic               wait_inst;
    } decode_info_t;

    typedef struct packed {
        logic         hit;
        decode_info_t info;
    } group_result_t;

    // record of a word that no pattern claims
    function automatic decode_info_t default_info(input logic [`INST_W-1:0] inst);
        decode_info_t info;
        info               = '0;
        info.inst          = inst;
        info.imm_type      = IMM_U5;
        info.addr_imm_type = ADDR_IMM_S26;
        return info;
    endfunction

endpackage

// File: design/branch_decoder.sv
`timescale 1ns/10ps
`include "decoder_settings.svh"

module branch_decoder
    import decode_pkg::*;
(
    input  logic [`INST_W-1:0] inst_i,
    output group_result_t      result_o
);

    decode_info_t info;
    logic         jump;
    logic         upper_imm;
    cmp_e         cond;

    // lu12i and pcaddu12i differ in bit 27 only
    assign upper_imm = (inst_i[31:`OP7_MSB] == 7'b0001010) ||
                       (inst_i[31:`OP7_MSB] == 7'b0001110);

    always_comb begin
        info = default_info(inst_i);
        jump = 1'b1;
        cond = CMP_NOCONDITION;
        unique case (inst_i[31:`OP6_MSB])
            6'b010011: begin                          // jirl
                info.reg_type_r1   = REG_R1_RJ;
                info.reg_type_w    = REG_W_RD;
                info.addr_imm_type = ADDR_IMM_S16;
                info.target_type   = TARGET_ABS;
            end
            6'b010100: info.target_type = TARGET_REL; // b
            6'b010101: begin                          // bl
                info.reg_type_w  = REG_W_BL1;
                info.target_type = TARGET_REL;
            end
            6'b010110: cond = CMP_E;
            6'b010111: cond = CMP_NE;
            6'b011000: cond = CMP_LT;
            6'b011001: cond = CMP_GE;
            6'b011010: cond = CMP_LTU;
            6'b011011: cond = CMP_GEU;
            default:   jump = 1'b0;
        endcase

        // conditional branches compare rd with rj
        if (cond != CMP_NOCONDITION) begin
            info.reg_type_r0   = REG_R0_RD;
            info.reg_type_r1   = REG_R1_RJ;
            info.addr_imm_type = ADDR_IMM_S16;
            info.target_type   = TARGET_REL;
            info.cmp_type      = cond;
        end

        if (jump) begin
            info.slot0     = 1'b1;
            info.jump_inst = 1'b1;
            if (info.reg_type_w != REG_W_NONE) begin
                info.alu_grand_op = GTYPE_LI; // link value is pc + 4
                info.alu_op       = STYPE_PCPLUS4;
            end
        end

        if (upper_imm) begin
            info.reg_type_r0  = REG_R0_IMM;
            info.reg_type_w   = REG_W_RD;
            info.imm_type     = IMM_S20;
            info.alu_grand_op = GTYPE_LI;
            info.alu_op       = inst_i[27] ? STYPE_PCADDUI : STYPE_LUI;
        end

        info.alu_inst = jump | upper_imm;
    end

    assign result_o.hit  = jump | upper_imm;
    assign result_o.info = info;

endmodule

// File: design/alu_decoder.sv
`timescale 1ns/10ps
`include "decoder_settings.svh"

module alu_decoder
    import decode_pkg::*;
(
    input  logic [`INST_W-1:0] inst_i,
    output group_result_t      result_o
);

    // operand form of a matched opcode
    typedef enum logic [1:0] {K_MISS, K_REG, K_IMM, K_MDU} kind_e;

    typedef struct packed {
        kind_e      kind;
        imm_e       imm;
        alu_gtype_e grand;
        alu_stype_t sub;
    } alu_row_t;

    alu_row_t     row;
    decode_info_t info;

    // ----------------------------------------------------------------------
    // opcode table
    // ----------------------------------------------------------------------
    always_comb begin
        unique casez (inst_i[31:`OP17_MSB])
            // 10-bit immediate forms
            17'b0000001000???????: row = '{K_IMM, IMM_S12, GTYPE_INT, STYPE_SLT};
            17'b0000001001???????: row = '{K_IMM, IMM_S12, GTYPE_INT, STYPE_SLTU};
            17'b0000001010???????: row = '{K_IMM, IMM_S12, GTYPE_INT, STYPE_ADD};
            17'b0000001101???????: row = '{K_IMM, IMM_U12, GTYPE_BW, STYPE_AND};
            17'b0000001110???????: row = '{K_IMM, IMM_U12, GTYPE_BW, STYPE_OR};
            17'b0000001111???????: row = '{K_IMM, IMM_U12, GTYPE_BW, STYPE_XOR};
            // register forms
            17'b00000000000100000: row = '{K_REG, IMM_U5, GTYPE_INT, STYPE_ADD};
            17'b00000000000100010: row = '{K_REG, IMM_U5, GTYPE_INT, STYPE_SUB};
            17'b00000000000100100: row = '{K_REG, IMM_U5, GTYPE_INT, STYPE_SLT};
            17'b00000000000100101: row = '{K_REG, IMM_U5, GTYPE_INT, STYPE_SLTU};
            17'b00000000000101000: row = '{K_REG, IMM_U5, GTYPE_BW, STYPE_NOR};
            17'b00000000000101001: row = '{K_REG, IMM_U5, GTYPE_BW, STYPE_AND};
            17'b00000000000101010: row = '{K_REG, IMM_U5, GTYPE_BW, STYPE_OR};
            17'b00000000000101011: row = '{K_REG, IMM_U5, GTYPE_BW, STYPE_XOR};
            17'b00000000000101110: row = '{K_REG, IMM_U5, GTYPE_SFT, STYPE_SLL};
            17'b00000000000101111: row = '{K_REG, IMM_U5, GTYPE_SFT, STYPE_SRL};
            17'b00000000000110000: row = '{K_REG, IMM_U5, GTYPE_SFT, STYPE_SRA};
            // multiply and divide leave the group field at zero
            17'b00000000000111000: row = '{K_MDU, IMM_U5, GTYPE_BW, MDU_MULL};
            17'b00000000000111001: row = '{K_MDU, IMM_U5, GTYPE_BW, MDU_MULH};
            17'b00000000000111010: row = '{K_MDU, IMM_U5, GTYPE_BW, MDU_MULHU};
            17'b00000000001000000: row = '{K_MDU, IMM_U5, GTYPE_BW, MDU_DIV};
            17'b00000000001000001: row = '{K_MDU, IMM_U5, GTYPE_BW, MDU_MOD};
            17'b00000000001000010: row = '{K_MDU, IMM_U5, GTYPE_BW, MDU_DIVU};
            17'b00000000001000011: row = '{K_MDU, IMM_U5, GTYPE_BW, MDU_MODU};
            // shift by a 5-bit immediate
            17'b00000000010000001: row = '{K_IMM, IMM_U5, GTYPE_SFT, STYPE_SLL};
            17'b00000000010001001: row = '{K_IMM, IMM_U5, GTYPE_SFT, STYPE_SRL};
            17'b00000000010010001: row = '{K_IMM, IMM_U5, GTYPE_SFT, STYPE_SRA};
            default:               row = '{K_MISS, IMM_U5, GTYPE_BW, STYPE_NOR};
        endcase
    end

    always_comb begin
        info = default_info(inst_i);
        if (row.kind != K_MISS) begin
            info.alu_inst     = (row.kind != K_MDU);
            info.mdu_inst     = (row.kind == K_MDU);
            info.reg_type_r0  = (row.kind == K_IMM) ? REG_R0_IMM : REG_R0_RK;
            info.reg_type_r1  = REG_R1_RJ;
            info.reg_type_w   = REG_W_RD;
            info.imm_type     = row.imm;
            info.alu_grand_op = row.grand;
            info.alu_op       = row.sub;
        end
    end

    assign result_o.hit  = (row.kind != K_MISS);
    assign result_o.info = info;

endmodule

// File: design/mem_decoder.sv
`timescale 1ns/10ps
`include "decoder_settings.svh"

module mem_decoder
    import decode_pkg::*;
(
    input  logic [`INST_W-1:0] inst_i,
    output group_result_t      result_o
);

    typedef enum logic [1:0] {M_MISS, M_LOAD, M_STORE} access_e;

    typedef struct packed {
        access_e access;
        logic    llsc;
        mem_e    size;
    } mem_row_t;

    mem_row_t     row;
    decode_info_t info;

    always_comb begin
        unique case (inst_i[31:`OP8_MSB])
            8'b00100000: row = '{M_LOAD, 1'b1, MEM_WORD};   // ll.w
            8'b00100001: row = '{M_STORE, 1'b1, MEM_WORD};  // sc.w
            default: begin
                unique case (inst_i[31:`OP10_MSB])
                    10'b0010100000: row = '{M_LOAD, 1'b0, MEM_BYTE};
                    10'b0010100001: row = '{M_LOAD, 1'b0, MEM_HALF};
                    10'b0010100010: row = '{M_LOAD, 1'b0, MEM_WORD};
                    10'b0010100100: row = '{M_STORE, 1'b0, MEM_BYTE};
                    10'b0010100101: row = '{M_STORE, 1'b0, MEM_HALF};
                    10'b0010100110: row = '{M_STORE, 1'b0, MEM_WORD};
                    10'b0010101000: row = '{M_LOAD, 1'b0, MEM_UBYTE};
                    10'b0010101001: row = '{M_LOAD, 1'b0, MEM_UHALF};
                    default:        row = '{M_MISS, 1'b0, MEM_BYTE};
                endcase
            end
        endcase
    end

    always_comb begin
        info = default_info(inst_i);
        if (row.access != M_MISS) begin
            info.lsu_inst      = 1'b1;
            info.reg_type_r0   = (row.access == M_STORE) ? REG_R0_RD : REG_R0_NONE;
            info.reg_type_r1   = REG_R1_RJ;                 // base address
            // sc hands its success flag back through rd
            info.reg_type_w    = (row.access == M_LOAD || row.llsc) ? REG_W_RD : REG_W_NONE;
            info.addr_imm_type = row.llsc ? ADDR_IMM_S14 : ADDR_IMM_S12;
            info.mem_type      = row.size;
            info.mem_read      = (row.access == M_LOAD);
            info.mem_write     = (row.access == M_STORE);
            info.llsc_inst     = row.llsc;
        end
    end

    assign result_o.hit  = (row.access != M_MISS);
    assign result_o.info = info;

endmodule

// File: design/priv_decoder.sv
`timescale 1ns/10ps
`include "decoder_settings.svh"

module priv_decoder
    import decode_pkg::*;
(
    input  logic [`INST_W-1:0] inst_i,
    output group_result_t      result_o
);

    logic         csr_hit;
    logic         brk_hit;
    logic         sys_hit;
    logic         idle_hit;
    logic         ertn_hit;
    logic         hit;
    decode_info_t info;

    // csrrd, csrwr and csrxchg share one opcode, rj picks the variant
    assign csr_hit  = (inst_i[31:`OP8_MSB] == 8'b00000100);
    assign brk_hit  = (inst_i[31:`OP17_MSB] == 17'b00000000001010100);
    assign sys_hit  = (inst_i[31:`OP17_MSB] == 17'b00000000001010110);
    assign idle_hit = (inst_i[31:`OP17_MSB] == 17'b00000110010010001);
    assign ertn_hit = (inst_i[31:`OP22_MSB] == 22'b0000011001001000001110);
    assign hit      = csr_hit | brk_hit | sys_hit | idle_hit | ertn_hit;

    always_comb begin
        info              = default_info(inst_i);
        info.alu_inst     = hit;
        info.slot0        = hit;        // all of these issue alone
        info.priv_inst    = csr_hit | idle_hit | ertn_hit;
        info.csr_op_en    = csr_hit;
        info.break_inst   = brk_hit;
        info.syscall_inst = sys_hit;
        info.wait_inst    = idle_hit;
        info.ertn_inst    = ertn_hit;
        if (csr_hit) begin
            info.reg_type_r0 = REG_R0_RD;
            info.reg_type_r1 = REG_R1_RJ;
            info.reg_type_w  = REG_W_RD;
        end
    end

    assign result_o.hit  = hit;
    assign result_o.info = info;

endmodule

// File: design/decode_ctrl.sv
`timescale 1ns/10ps

module decode_ctrl
    import decode_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n_i,
    input  logic          inst_valid_i,
    input  group_result_t branch_i,
    input  group_result_t alu_i,
    input  group_result_t mem_i,
    input  group_result_t priv_i,
    output logic          out_valid_o,
    output logic          decode_err_o,
    output decode_info_t  info_o
);

    logic [3:0]   hits;
    decode_info_t sel_info;

    assign hits = {branch_i.hit, alu_i.hit, mem_i.hit, priv_i.hit};

    // a group that misses still drives the default record, so the branch
    // result doubles as the fallback
    always_comb begin
        case (hits)
            4'b0100: sel_info = alu_i.info;
            4'b0010: sel_info = mem_i.info;
            4'b0001: sel_info = priv_i.info;
            default: sel_info = branch_i.info;
        endcase
    end

    // ----------------------------------------------------------------------
    // output register
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_valid_o  <= 1'b0;
            decode_err_o <= 1'b0;
            info_o       <= '0;
        end else begin
            out_valid_o <= inst_valid_i;
            if (inst_valid_i) begin
                decode_err_o <= ~|hits;
                info_o       <= sel_info;
            end
        end
    end

    // the four opcode tables are disjoint
    a_one_hit: assert property (@(posedge clk) disable iff (!rst_n_i)
        inst_valid_i |-> $onehot0(hits));

    // an unclaimed word must leave the branch decoder with the bare default record
    a_fallback: assert property (@(posedge clk) disable iff (!rst_n_i)
        inst_valid_i && hits == 4'b0000 |-> sel_info == default_info(sel_info.inst));

endmodule

// File: design/inst_decoder.sv
`timescale 1ns/10ps
`include "decoder_settings.svh"

module inst_decoder
    import decode_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               inst_valid_i,
    input  logic [`INST_W-1:0] inst_i,
    output logic               out_valid_o,
    output logic               decode_err_o,
    output decode_info_t       info_o
);

    group_result_t branch_res;
    group_result_t alu_res;
    group_result_t mem_res;
    group_result_t priv_res;

    branch_decoder u_branch (
        .inst_i   (inst_i),
        .result_o (branch_res)
    );

    alu_decoder u_alu (
        .inst_i   (inst_i),
        .result_o (alu_res)
    );

    mem_decoder u_mem (
        .inst_i   (inst_i),
        .result_o (mem_res)
    );

    priv_decoder u_priv (
        .inst_i   (inst_i),
        .result_o (priv_res)
    );

    decode_ctrl u_ctrl (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_valid_i (inst_valid_i),
        .branch_i     (branch_res),
        .alu_i        (alu_res),
        .mem_i        (mem_res),
        .priv_i       (priv_res),
        .out_valid_o  (out_valid_o),
        .decode_err_o (decode_err_o),
        .info_o       (info_o)
    );

endmodule

// File: dv/tb_inst_decoder.sv
`timescale 1ns/10ps
`include "decoder_settings.svh"

module tb_inst_decoder
    import decode_pkg::*;
();

    localparam int CLK_PERIOD = 40;
    localparam int N_RANDOM   = 40;

    // 10-bit prefixes: immediate ALU ops, then loads and stores
    localparam logic [9:0] OP10_LIST [14] = '{
        10'h008, 10'h009, 10'h00a, 10'h00d, 10'h00e, 10'h00f,
        10'h0a0, 10'h0a1, 10'h0a2, 10'h0a4, 10'h0a5, 10'h0a6, 10'h0a8, 10'h0a9};
    // 17-bit prefixes: register ops, mul and div, shift by immediate, break, syscall, idle
    localparam logic [16:0] OP17_LIST [24] = '{
        17'h020, 17'h022, 17'h024, 17'h025, 17'h028, 17'h029, 17'h02a, 17'h02b,
        17'h02e, 17'h02f, 17'h030, 17'h038, 17'h039, 17'h03a, 17'h040, 17'h041,
        17'h042, 17'h043, 17'h081, 17'h089, 17'h091, 17'h054, 17'h056, 17'hc91};
    // tlb ops, cacop, preld, dbar, ibar and the counter reads no longer decode
    localparam logic [31:0] DROPPED_LIST [11] = '{
        32'h06482800, 32'h06482c00, 32'h06483000, 32'h06483400, 32'h06498000,
        32'h06000000, 32'h2ac00000, 32'h38720000, 32'h38728000, 32'h00006000,
        32'h00006400};

    logic               clk;
    logic               rst_n_i;
    logic               inst_valid_i;
    logic [`INST_W-1:0] inst_i;
    logic               out_valid_o;
    logic               decode_err_o;
    decode_info_t       info_o;

    logic [`INST_W-1:0] words[$];
    group_result_t      expected;
    group_result_t      exp_q;       // expectation of the previous cycle
    int                 valid_errs;
    int                 flag_errs;
    int                 info_errs;
    int                 hold_errs;
    int                 reset_errs;

    inst_decoder u_dut (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .out_valid_o  (out_valid_o),
        .decode_err_o (decode_err_o),
        .info_o       (info_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // --------------------------------------------------------------------
    // reference rules
    // --------------------------------------------------------------------
    function automatic group_result_t rule_table(input logic [`INST_W-1:0] w);
        group_result_t r;
        logic [5:0]    op6;
        logic [9:0]    op10;
        logic [16:0]   op17;
        logic          alu_hit;
        logic [8:0]    alu_row;   // imm form, mdu, imm kind, group, sub-op
        logic [4:0]    mem_row;   // load, store, size
        logic          llsc;
        logic          csr, brk, sys, idle, ertn;
        op6                  = w[31:`OP6_MSB];
        op10                 = w[31:`OP10_MSB];
        op17                 = w[31:`OP17_MSB];
        r                    = '0;
        r.info.inst          = w;
        r.info.imm_type      = IMM_U5;
        r.info.addr_imm_type = ADDR_IMM_S26;

        if (op6 >= 6'h13 && op6 <= 6'h1b) begin
            r.hit              = 1'b1;
            r.info.alu_inst    = 1'b1;
            r.info.slot0       = 1'b1;
            r.info.jump_inst   = 1'b1;
            r.info.target_type = TARGET_REL;
            if (op6 == 6'h13) begin              // jirl links through rd
                r.info.target_type   = TARGET_ABS;
                r.info.reg_type_r1   = REG_R1_RJ;
                r.info.reg_type_w    = REG_W_RD;
                r.info.addr_imm_type = ADDR_IMM_S16;
            end else if (op6 == 6'h15) begin
                r.info.reg_type_w = REG_W_BL1;
            end else if (op6 != 6'h14) begin
                r.info.reg_type_r0   = REG_R0_RD;
                r.info.reg_type_r1   = REG_R1_RJ;
                r.info.addr_imm_type = ADDR_IMM_S16;
                r.info.cmp_type      = cmp_e'(4'(op6 - 6'h15));
            end
            if (r.info.reg_type_w != REG_W_NONE) begin
                r.info.alu_grand_op = GTYPE_LI;
                r.info.alu_op       = STYPE_PCPLUS4;
            end
        end

        if (w[31:`OP7_MSB] == 7'h0a || w[31:`OP7_MSB] == 7'h0e) begin
            r.hit               = 1'b1;
            r.info.alu_inst     = 1'b1;
            r.info.reg_type_r0  = REG_R0_IMM;
            r.info.reg_type_w   = REG_W_RD;
            r.info.imm_type     = IMM_S20;
            r.info.alu_grand_op = GTYPE_LI;
            r.info.alu_op = (w[31:`OP7_MSB] == 7'h0e) ? STYPE_PCADDUI : STYPE_LUI;
        end

        alu_hit = 1'b1;
        alu_row = '0;
        case (op10)
            10'h008: alu_row = {2'b10, IMM_S12, GTYPE_INT, STYPE_SLT};
            10'h009: alu_row = {2'b10, IMM_S12, GTYPE_INT, STYPE_SLTU};
            10'h00a: alu_row = {2'b10, IMM_S12, GTYPE_INT, STYPE_ADD};
            10'h00d: alu_row = {2'b10, IMM_U12, GTYPE_BW, STYPE_AND};
            10'h00e: alu_row = {2'b10, IMM_U12, GTYPE_BW, STYPE_OR};
            10'h00f: alu_row = {2'b10, IMM_U12, GTYPE_BW, STYPE_XOR};
            default: begin
                case (op17)
                    17'h020: alu_row = {2'b00, IMM_U5, GTYPE_INT, STYPE_ADD};
                    17'h022: alu_row = {2'b00, IMM_U5, GTYPE_INT, STYPE_SUB};
                    17'h024: alu_row = {2'b00, IMM_U5, GTYPE_INT, STYPE_SLT};
                    17'h025: alu_row = {2'b00, IMM_U5, GTYPE_INT, STYPE_SLTU};
                    17'h028: alu_row = {2'b00, IMM_U5, GTYPE_BW, STYPE_NOR};
                    17'h029: alu_row = {2'b00, IMM_U5, GTYPE_BW, STYPE_AND};
                    17'h02a: alu_row = {2'b00, IMM_U5, GTYPE_BW, STYPE_OR};
                    17'h02b: alu_row = {2'b00, IMM_U5, GTYPE_BW, STYPE_XOR};
                    17'h02e: alu_row = {2'b00, IMM_U5, GTYPE_SFT, STYPE_SLL};
                    17'h02f: alu_row = {2'b00, IMM_U5, GTYPE_SFT, STYPE_SRL};
                    17'h030: alu_row = {2'b00, IMM_U5, GTYPE_SFT, STYPE_SRA};
                    17'h038: alu_row = {2'b01, IMM_U5, GTYPE_BW, MDU_MULL};
                    17'h039: alu_row = {2'b01, IMM_U5, GTYPE_BW, MDU_MULH};
                    17'h03a: alu_row = {2'b01, IMM_U5, GTYPE_BW, MDU_MULHU};
                    17'h040: alu_row = {2'b01, IMM_U5, GTYPE_BW, MDU_DIV};
                    17'h041: alu_row = {2'b01, IMM_U5, GTYPE_BW, MDU_MOD};
                    17'h042: alu_row = {2'b01, IMM_U5, GTYPE_BW, MDU_DIVU};
                    17'h043: alu_row = {2'b01, IMM_U5, GTYPE_BW, MDU_MODU};
                    17'h081: alu_row = {2'b10, IMM_U5, GTYPE_SFT, STYPE_SLL};
                    17'h089: alu_row = {2'b10, IMM_U5, GTYPE_SFT, STYPE_SRL};
                    17'h091: alu_row = {2'b10, IMM_U5, GTYPE_SFT, STYPE_SRA};
                    default: alu_hit = 1'b0;
                endcase
            end
        endcase
        if (alu_hit) begin
            r.hit               = 1'b1;
            r.info.alu_inst     = !alu_row[7];
            r.info.mdu_inst     = alu_row[7];
            r.info.reg_type_r0  = alu_row[8] ? REG_R0_IMM : REG_R0_RK;
            r.info.reg_type_r1  = REG_R1_RJ;
            r.info.reg_type_w   = REG_W_RD;
            r.info.imm_type     = imm_e'(alu_row[6:5]);
            r.info.alu_grand_op = alu_gtype_e'(alu_row[4:3]);
            r.info.alu_op       = alu_row[2:0];
        end

        llsc    = 1'b0;
        mem_row = '0;
        case (w[31:`OP8_MSB])
            8'h20: {llsc, mem_row} = {1'b1, 2'b10, MEM_WORD};
            8'h21: {llsc, mem_row} = {1'b1, 2'b01, MEM_WORD};
            default: begin
                case (op10)
                    10'h0a0: mem_row = {2'b10, MEM_BYTE};
                    10'h0a1: mem_row = {2'b10, MEM_HALF};
                    10'h0a2: mem_row = {2'b10, MEM_WORD};
                    10'h0a4: mem_row = {2'b01, MEM_BYTE};
                    10'h0a5: mem_row = {2'b01, MEM_HALF};
                    10'h0a6: mem_row = {2'b01, MEM_WORD};
                    10'h0a8: mem_row = {2'b10, MEM_UBYTE};
                    10'h0a9: mem_row = {2'b10, MEM_UHALF};
                    default: mem_row = '0;
                endcase
            end
        endcase
        if (mem_row[4] || mem_row[3]) begin
            r.hit                = 1'b1;
            r.info.lsu_inst      = 1'b1;
            r.info.reg_type_r0   = mem_row[3] ? REG_R0_RD : REG_R0_NONE;
            r.info.reg_type_r1   = REG_R1_RJ;
            r.info.reg_type_w    = (mem_row[4] || llsc) ? REG_W_RD : REG_W_NONE;
            r.info.addr_imm_type = llsc ? ADDR_IMM_S14 : ADDR_IMM_S12;
            r.info.mem_type      = mem_e'(mem_row[2:0]);
            r.info.mem_read      = mem_row[4];
            r.info.mem_write     = mem_row[3];
            r.info.llsc_inst     = llsc;
        end

        csr  = (w[31:`OP8_MSB] == 8'h04);
        brk  = (op17 == 17'h054);
        sys  = (op17 == 17'h056);
        idle = (op17 == 17'hc91);
        ertn = (w[31:`OP22_MSB] == 22'h1920e);
        if (csr || brk || sys || idle || ertn) begin
            r.hit                = 1'b1;
            r.info.alu_inst      = 1'b1;
            r.info.slot0         = 1'b1;
            r.info.priv_inst     = csr | idle | ertn;
            r.info.csr_op_en     = csr;
            r.info.syscall_inst  = sys;
            r.info.break_inst    = brk;
            r.info.ertn_inst     = ertn;
            r.info.wait_inst     = idle;
            if (csr) begin
                r.info.reg_type_r0 = REG_R0_RD;
                r.info.reg_type_r1 = REG_R1_RJ;
                r.info.reg_type_w  = REG_W_RD;
            end
        end
        return r;
    endfunction

    always_comb expected = rule_table(inst_i);

    always @(posedge clk) exp_q <= expected;

    // --------------------------------------------------------------------
    // checks
    // --------------------------------------------------------------------
    a_out_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
        inst_valid_i |=> out_valid_o)
        else begin
            valid_errs++;
            $display("ERROR out_valid_o expected %h got %h", 1'b1, $sampled(out_valid_o));
        end

    a_err_flag: assert property (@(posedge clk) disable iff (!rst_n_i)
        inst_valid_i |=> decode_err_o == !exp_q.hit)
        else begin
            flag_errs++;
            $display("ERROR decode_err_o expected %h got %h (inst %h)",
                     $sampled(!exp_q.hit), $sampled(decode_err_o), $sampled(exp_q.info.inst));
        end

    a_record: assert property (@(posedge clk) disable iff (!rst_n_i)
        inst_valid_i |=> info_o == exp_q.info)
        else begin
            info_errs++;
            $display("ERROR info_o expected %h got %h", $sampled(exp_q.info), $sampled(info_o));
        end

    // no strobe, so nothing new may appear
    a_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        !inst_valid_i |=> !out_valid_o && $stable(info_o) && $stable(decode_err_o))
        else begin
            hold_errs++;
            $display("outputs changed or out_valid_o rose in a cycle after no strobe");
        end

    // --------------------------------------------------------------------
    // stimulus
    // --------------------------------------------------------------------
    task automatic expect_zero(input string name, input logic [127:0] got);
        assert (got == '0)
            else begin
                reset_errs++;
                $display("ERROR %s expected %h got %h", name, 128'h0, got);
            end
    endtask

    // prefix on top, random operand fields below
    task automatic push_op(input logic [31:0] prefix, input int len);
        words.push_back((prefix << (32 - len)) | ($urandom() >> len));
    endtask

    task automatic build_stimulus();
        for (int op = 'h13; op <= 'h1b; op++) push_op(op, 6);
        push_op(32'h0a, 7);
        push_op(32'h0e, 7);
        push_op(32'h20, 8);
        push_op(32'h21, 8);
        push_op(32'h04, 8);
        push_op(32'h1920e, 22);
        foreach (OP10_LIST[i]) push_op(32'(OP10_LIST[i]), 10);
        foreach (OP17_LIST[i]) push_op(32'(OP17_LIST[i]), 17);
        foreach (DROPPED_LIST[i]) words.push_back(DROPPED_LIST[i]);
        repeat (N_RANDOM) words.push_back($urandom());
    endtask

    task automatic send_word(input logic [`INST_W-1:0] w);
        @(negedge clk);
        inst_valid_i = 1'b1;
        inst_i       = w;
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        inst_valid_i = 1'b0;
        inst_i       = $urandom();      // must not reach the outputs
    endtask

    initial begin
        int unsigned seed;
        seed         = $urandom(9963);
        rst_n_i      = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        valid_errs   = 0;
        flag_errs    = 0;
        info_errs    = 0;
        hold_errs    = 0;
        reset_errs   = 0;
        build_stimulus();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        expect_zero("out_valid_o", out_valid_o);
        expect_zero("decode_err_o", decode_err_o);
        expect_zero("info_o", info_o);

        foreach (words[i]) begin
            send_word(words[i]);
            if ($urandom_range(2) == 0) idle_cycle();
        end
        repeat (3) idle_cycle();

        $display("error counts: valid %0d, decode_err %0d, record %0d, hold %0d, reset %0d",
                 valid_errs, flag_errs, info_errs, hold_errs, reset_errs);
        if (valid_errs + flag_errs + info_errs + hold_errs + reset_errs == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // each word takes at most two cycles, plus reset and the tail
    initial begin
        int limit;
        #1;
        limit = (words.size() * 2 + 20) * CLK_PERIOD;
        #(limit);
        $display("watchdog expired before the stimulus finished");
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: sources.f
+incdir+include
design/decode_pkg.sv
design/branch_decoder.sv
design/alu_decoder.sv
design/mem_decoder.sv
design/priv_decoder.sv
design/decode_ctrl.sv
design/inst_decoder.sv
dv/tb_inst_decoder.sv
